/* hw/expand_out_stage.sv */
`default_nettype none

module expand_out_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cand_valid,
    input  rvc_pkg::expanded_instr_t cand_instr,
    output logic                     cand_accept,
    input  logic                     out_credit,
    output logic                     out_valid,
    output rvc_pkg::expanded_instr_t out_instr
);

    logic [rvc_pkg::OUT_CREDIT_W-1:0] credit_q;  // Free decode-stage slots
    logic                             send;

    assign cand_accept = credit_q != '0;
    assign send        = cand_valid && cand_accept;

    //////////////////////////////
    // Downstream credits
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_q  <= rvc_pkg::OUT_CREDIT_INIT;
            out_valid <= 1'b0;
        end else begin
            case ({send, out_credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;  // Send and return cancel out
            endcase
            out_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_instr <= cand_instr;
        end
    end

endmodule

`default_nettype wire

/* hw/parcel_aligner.sv */
`default_nettype none

module parcel_aligner (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_valid,
    input  rvc_pkg::fetch_word_t fetch_data,
    output logic                 fetch_credit,
    input  logic                 cand_accept,
    output logic                 cand_valid,
    output rvc_pkg::rvc_parcel_u cand_parcel,
    output logic [15:0]          cand_upper,
    output logic [31:0]          cand_pc,
    output logic                 cand_is_compressed
);

    // Entry 0 is the oldest parcel
    logic [rvc_pkg::BUF_PARCELS-1:0][rvc_pkg::PARCEL_W-1:0] buf_q;
    logic [rvc_pkg::BUF_PARCELS-1:0][rvc_pkg::PARCEL_W-1:0] buf_shift;
    logic [rvc_pkg::BUF_PARCELS-1:0][rvc_pkg::PARCEL_W-1:0] buf_d;

    logic [rvc_pkg::BUF_CNT_W-1:0] count_q;
    logic [rvc_pkg::BUF_CNT_W-1:0] remain;
    logic [rvc_pkg::BUF_CNT_W-1:0] count_d;
    logic [rvc_pkg::BUF_IDX_W-1:0] idx_lo;
    logic [rvc_pkg::BUF_IDX_W-1:0] idx_hi;
    logic [rvc_pkg::XLEN-1:0]      pc_q;
    logic [1:0]                    take;      // Parcels consumed this cycle
    logic [1:0]                    consumed;
    logic                          cons_q;    // Odd parcel left over from last credit
    logic                          head_comp;

    //////////////////////////////
    // Candidate instruction
    //////////////////////////////
    assign head_comp = buf_q[0][1:0] != 2'b11;

    always_comb begin
        if (count_q == '0) begin
            cand_valid = 1'b0;
        end else if (head_comp) begin
            cand_valid = 1'b1;
        end else begin
            cand_valid = count_q >= 2;  // Upper half must be buffered
        end
    end

    assign cand_parcel        = buf_q[0];
    assign cand_upper         = buf_q[1];
    assign cand_pc            = pc_q;
    assign cand_is_compressed = head_comp;

    always_comb begin
        if (cand_valid && cand_accept) begin
            take = head_comp ? 2'd1 : 2'd2;
        end else begin
            take = 2'd0;
        end
    end

    //////////////////////////////
    // Buffer update
    //////////////////////////////
    assign remain  = count_q - {1'b0, take};
    assign count_d = remain + {fetch_valid, 1'b0};
    assign idx_lo  = remain[rvc_pkg::BUF_IDX_W-1:0];
    assign idx_hi  = idx_lo + 1'b1;

    always_comb begin
        buf_shift = buf_q >> (take * rvc_pkg::PARCEL_W);
        buf_d     = buf_shift;
        if (fetch_valid) begin
            // New word lands right behind what is left
            buf_d[idx_lo] = fetch_data.lo_parcel;
            buf_d[idx_hi] = fetch_data.hi_parcel;
        end
    end

    always_ff @(posedge clk) begin
        buf_q <= buf_d;
    end

    // One credit back per word's worth of consumed parcels
    assign consumed = {1'b0, cons_q} + take;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q      <= '0;
            cons_q       <= 1'b0;
            fetch_credit <= 1'b0;
            pc_q         <= rvc_pkg::RESET_PC;
        end else begin
            count_q      <= count_d;
            cons_q       <= consumed[0];
            fetch_credit <= consumed[1];
            pc_q         <= pc_q + {take, 1'b0};  // 2 or 4 bytes
        end
    end

endmodule

`default_nettype wire

/* hw/rvc_expander.sv */
`default_nettype none

module rvc_expander (
    input  rvc_pkg::rvc_parcel_u parcel,
    output logic [31:0]          instr,
    output logic                 illegal
);

    logic [15:0] c;          // Raw bits for scattered immediates
    logic [31:0] exp_instr;
    logic        bad;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;        // x8..x15
    logic [4:0]  rs1p;
    logic [11:0] imm6_sx;
    logic [19:0] jal_imm;
    logic [5:0]  lui_imm;

    assign c       = parcel;
    assign rd      = parcel.cr.rd_rs1;
    assign rs2     = parcel.cr.rs2;
    assign rdp     = {2'b01, parcel.cp.rdp_rs2p};
    assign rs1p    = {2'b01, parcel.cp.rs1p};
    assign imm6_sx = {{6{c[12]}}, c[12], c[6:2]};
    assign lui_imm = {c[12], c[6:2]};

    // imm[20|10:1|11|19:12] of JAL
    assign jal_imm = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                      c[12], {8{c[12]}}};

    always_comb begin
        exp_instr = '0;
        bad       = 1'b0;
        case ({parcel.cp.funct3, parcel.cp.op})
            //////////////////////////////
            // Quadrant 0
            //////////////////////////////
            {3'b010, rvc_pkg::QUAD0}: begin  // C.LW
                exp_instr = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1p, 3'b010, rdp,
                             rvc_pkg::OPC_LOAD};
            end
            {3'b110, rvc_pkg::QUAD0}: begin  // C.SW
                exp_instr = {5'b0, c[5], c[12], rdp, rs1p, 3'b010, c[11:10], c[6], 2'b00,
                             rvc_pkg::OPC_STORE};
            end

            //////////////////////////////
            // Quadrant 1
            //////////////////////////////
            {3'b000, rvc_pkg::QUAD1}: begin  // C.ADDI, C.NOP when all zero
                exp_instr = {imm6_sx, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
            end
            {3'b001, rvc_pkg::QUAD1}: exp_instr = {jal_imm, 5'd1, rvc_pkg::OPC_JAL};  // C.JAL
            {3'b101, rvc_pkg::QUAD1}: exp_instr = {jal_imm, 5'd0, rvc_pkg::OPC_JAL};  // C.J
            {3'b010, rvc_pkg::QUAD1}: begin  // C.LI
                exp_instr = {imm6_sx, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
            end
            {3'b011, rvc_pkg::QUAD1}: begin
                // rd x2 is C.ADDI16SP, zero immediate is reserved
                if (rd == 5'd2 || lui_imm == '0) begin
                    bad = 1'b1;
                end else begin
                    exp_instr = {{14{c[12]}}, lui_imm, rd, rvc_pkg::OPC_LUI};
                end
            end
            {3'b100, rvc_pkg::QUAD1}: begin
                case (c[11:10])
                    2'b00: begin  // C.SRLI
                        bad       = c[12];  // shamt[5] reserved on RV32
                        exp_instr = {7'b0000000, c[6:2], rs1p, 3'b101, rs1p, rvc_pkg::OPC_OP_IMM};
                    end
                    2'b01: begin  // C.SRAI
                        bad       = c[12];
                        exp_instr = {7'b0100000, c[6:2], rs1p, 3'b101, rs1p, rvc_pkg::OPC_OP_IMM};
                    end
                    2'b10: begin  // C.ANDI
                        exp_instr = {imm6_sx, rs1p, 3'b111, rs1p, rvc_pkg::OPC_OP_IMM};
                    end
                    default: begin
                        bad = c[12];  // SUBW/ADDW and reserved
                        case (parcel.cp.imm_mid)
                            2'b00: exp_instr = {7'b0100000, rdp, rs1p, 3'b000, rs1p, rvc_pkg::OPC_OP};
                            2'b01: exp_instr = {7'b0000000, rdp, rs1p, 3'b100, rs1p, rvc_pkg::OPC_OP};
                            2'b10: exp_instr = {7'b0000000, rdp, rs1p, 3'b110, rs1p, rvc_pkg::OPC_OP};
                            default: exp_instr = {7'b0000000, rdp, rs1p, 3'b111, rs1p, rvc_pkg::OPC_OP};
                        endcase
                    end
                endcase
            end
            {3'b110, rvc_pkg::QUAD1}: begin  // C.BEQZ
                exp_instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 3'b000, c[11:10], c[4:3],
                             c[12], rvc_pkg::OPC_BRANCH};
            end
            {3'b111, rvc_pkg::QUAD1}: begin  // C.BNEZ
                exp_instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 3'b001, c[11:10], c[4:3],
                             c[12], rvc_pkg::OPC_BRANCH};
            end

            //////////////////////////////
            // Quadrant 2
            //////////////////////////////
            {3'b000, rvc_pkg::QUAD2}: begin  // C.SLLI
                bad       = c[12];
                exp_instr = {7'b0000000, c[6:2], rd, 3'b001, rd, rvc_pkg::OPC_OP_IMM};
            end
            {3'b100, rvc_pkg::QUAD2}: begin
                if (rs2 == 5'd0) begin
                    // C.JR / C.JALR, rs1 x0 is reserved or C.EBREAK
                    bad       = rd == 5'd0;
                    exp_instr = {12'b0, rd, 3'b000, {4'b0, parcel.cr.funct4[0]},
                                 rvc_pkg::OPC_JALR};
                end else if (!parcel.cr.funct4[0]) begin
                    exp_instr = {7'b0, rs2, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP};  // C.MV
                end else begin
                    exp_instr = {7'b0, rs2, rd, 3'b000, rd, rvc_pkg::OPC_OP};    // C.ADD
                end
            end
            default: bad = 1'b1;  // Outside the supported subset
        endcase
    end

    assign illegal = bad;
    assign instr   = bad ? 32'h0 : exp_instr;

endmodule

`default_nettype wire

/* hw/rvc_fetch_unit.sv */
`default_nettype none

module rvc_fetch_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_valid,
    input  rvc_pkg::fetch_word_t     fetch_data,
    output logic                     fetch_credit,
    output logic                     out_valid,
    output rvc_pkg::expanded_instr_t out_instr,
    input  logic                     out_credit
);

    logic                     cand_valid;
    logic                     cand_accept;
    rvc_pkg::rvc_parcel_u     cand_parcel;
    logic [15:0]              cand_upper;
    logic [31:0]              cand_pc;
    logic                     cand_is_compressed;
    logic [31:0]              exp_instr;
    logic                     exp_illegal;
    rvc_pkg::expanded_instr_t cand_instr;

    parcel_aligner aligner_i (
        .clk                (clk),
        .rst                (rst),
        .fetch_valid        (fetch_valid),
        .fetch_data         (fetch_data),
        .fetch_credit       (fetch_credit),
        .cand_accept        (cand_accept),
        .cand_valid         (cand_valid),
        .cand_parcel        (cand_parcel),
        .cand_upper         (cand_upper),
        .cand_pc            (cand_pc),
        .cand_is_compressed (cand_is_compressed)
    );

    rvc_expander expander_i (
        .parcel  (cand_parcel),
        .instr   (exp_instr),
        .illegal (exp_illegal)
    );

    // 32-bit instructions bypass the expander
    assign cand_instr = '{
        instr:      cand_is_compressed ? exp_instr : {cand_upper, cand_parcel},
        pc:         cand_pc,
        compressed: cand_is_compressed,
        illegal:    cand_is_compressed && exp_illegal
    };

    expand_out_stage out_stage_i (
        .clk         (clk),
        .rst         (rst),
        .cand_valid  (cand_valid),
        .cand_instr  (cand_instr),
        .cand_accept (cand_accept),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_instr   (out_instr)
    );

endmodule

`default_nettype wire

/* hw/rvc_pkg.sv */
`default_nettype none

package rvc_pkg;

    //////////////////////////////
    // Sizes and reset values
    //////////////////////////////
    localparam int XLEN             = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam int PARCEL_W         = 16;
    localparam int FETCH_CREDITS    = 2;   // Words the parcel buffer can hold
    localparam int BUF_PARCELS      = FETCH_CREDITS * 2;
    localparam int BUF_CNT_W        = $clog2(BUF_PARCELS + 1);
    localparam int BUF_IDX_W        = $clog2(BUF_PARCELS);
    localparam int OUT_CREDITS      = 4;   // Decode-stage slots
    localparam int OUT_CREDIT_W     = $clog2(OUT_CREDITS + 1);
    localparam logic [OUT_CREDIT_W-1:0] OUT_CREDIT_INIT = OUT_CREDIT_W'(OUT_CREDITS);

    //////////////////////////////
    // Quadrants and opcodes
    //////////////////////////////
    localparam logic [1:0] QUAD0 = 2'b00;
    localparam logic [1:0] QUAD1 = 2'b01;
    localparam logic [1:0] QUAD2 = 2'b10;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // Fetch word, lo_parcel comes first in program order
    typedef struct packed {
        logic [PARCEL_W-1:0] hi_parcel;
        logic [PARCEL_W-1:0] lo_parcel;
    } fetch_word_t;

    // Register-operand view (CR format)
    typedef struct packed {
        logic [3:0] funct4;
        logic [4:0] rd_rs1;
        logic [4:0] rs2;
        logic [1:0] op;
    } rvc_cr_t;

    // Prime-register view (CL/CS/CB formats)
    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] imm_hi;
        logic [2:0] rs1p;
        logic [1:0] imm_mid;
        logic [2:0] rdp_rs2p;
        logic [1:0] op;
    } rvc_cp_t;

    typedef union packed {
        rvc_cr_t cr;
        rvc_cp_t cp;
    } rvc_parcel_u;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic            compressed;
        logic            illegal;
    } expanded_instr_t;

endpackage

`default_nettype wire

/* tb.f */
hw/rvc_pkg.sv
hw/parcel_aligner.sv
hw/rvc_expander.sv
hw/expand_out_stage.sv
hw/rvc_fetch_unit.sv
verification/rvc_fetch_unit_assert.sv
verification/rvc_fetch_unit_tb.sv

/* verification/rvc_fetch_unit_assert.sv */
`default_nettype none

module rvc_fetch_unit_assert (
    input logic                             clk,
    input logic                             rst,
    input logic [rvc_pkg::OUT_CREDIT_W-1:0] credit_q,
    input logic                             out_credit,
    input logic                             out_valid,
    input rvc_pkg::expanded_instr_t         out_instr
);

    logic [rvc_pkg::OUT_CREDIT_W:0] held_q;  // Delivered and not yet credited

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q <= '0;
        end else begin
            held_q <= held_q + out_valid - out_credit;
        end
    end

    //////////////////////////////
    // Decode-side credit rules
    //////////////////////////////
    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_q <= rvc_pkg::OUT_CREDITS)
        else $error("Credit counter above the number of decode slots");

    // A new delivery needs a free decode slot
    no_send_empty: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> held_q < rvc_pkg::OUT_CREDITS)
        else $error("Instruction sent with no credit left");

    illegal_zero: assert property (@(posedge clk)
        out_valid && out_instr.illegal |-> out_instr.instr == '0)
        else $error("Illegal instruction with nonzero encoding");

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !out_valid)  // Output idle through reset
        else $error("out_valid high during reset");

endmodule

bind expand_out_stage rvc_fetch_unit_assert assert_i (
    .clk        (clk),
    .rst        (rst),
    .credit_q   (credit_q),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_instr  (out_instr)
);

`default_nettype wire

/* verification/rvc_fetch_unit_tb.sv */
`default_nettype none

module rvc_fetch_unit_tb;

    typedef struct packed {
        logic [31:0] code;         // A 16-bit parcel sits in bits 15:0
        logic [31:0] exp_instr;
        logic        exp_illegal;
    } table_entry_t;

    localparam int NUM_ENTRIES = 36;
    localparam int CLK_PERIOD  = 40;
    localparam int LIMIT       = NUM_ENTRIES * CLK_PERIOD * 20;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     fetch_valid;
    rvc_pkg::fetch_word_t     fetch_data;
    logic                     fetch_credit;
    logic                     out_valid;
    rvc_pkg::expanded_instr_t out_instr;
    logic                     out_credit;

    //////////////////////////////
    // Program in order
    //////////////////////////////
    table_entry_t tbl [NUM_ENTRIES] = '{
        '{32'h0010_0093, 32'h0010_0093, 1'b0},  // addi x1, x0, 1 on a word boundary
        '{32'h0000_4144, 32'h0045_2483, 1'b0},  // C.LW x9, 4(x10)
        '{32'h1234_5137, 32'h1234_5137, 1'b0},  // lui x2 across two words
        '{32'h0000_C60C, 32'h00B6_2423, 1'b0},  // C.SW x11, 8(x12)
        '{32'h0000_A021, 32'h0080_006F, 1'b0},  // C.J +8
        '{32'h0000_3FF5, 32'hFFDF_F0EF, 1'b0},  // C.JAL -4
        '{32'h0000_C019, 32'h0004_0363, 1'b0},  // C.BEQZ x8, +6
        '{32'h0000_FFFD, 32'hFE07_9FE3, 1'b0},  // C.BNEZ x15, -2
        '{32'h0000_52FD, 32'hFFF0_0293, 1'b0},  // C.LI x5, -1
        '{32'h0000_6305, 32'h0000_1337, 1'b0},  // C.LUI x6, 1
        '{32'h0000_73FD, 32'hFFFF_F3B7, 1'b0},  // C.LUI x7, negative
        '{32'h0000_050D, 32'h0035_0513, 1'b0},  // C.ADDI x10, 3
        '{32'h0000_0001, 32'h0000_0013, 1'b0},  // C.NOP
        '{32'h0000_0000, 32'h0000_0000, 1'b1},  // All-zero parcel
        '{32'h0000_0612, 32'h0046_1613, 1'b0},  // C.SLLI x12, 4
        '{32'h0020_81B3, 32'h0020_81B3, 1'b0},  // add x3, x1, x2 across two words
        '{32'h0000_8089, 32'h0024_D493, 1'b0},  // C.SRLI x9, 2
        '{32'h0000_877D, 32'h41F7_5713, 1'b0},  // C.SRAI x14, 31
        '{32'h0000_9841, 32'hFF04_7413, 1'b0},  // C.ANDI x8, -16
        '{32'h0000_8C05, 32'h4094_0433, 1'b0},  // C.SUB x8, x9
        '{32'h0000_8D2D, 32'h00B5_4533, 1'b0},  // C.XOR x10, x11
        '{32'h0000_8E55, 32'h00D6_6633, 1'b0},  // C.OR x12, x13
        '{32'h0000_8F7D, 32'h00F7_7733, 1'b0},  // C.AND x14, x15
        '{32'h0000_8082, 32'h0000_8067, 1'b0},  // C.JR x1
        '{32'h0000_9002, 32'h0000_0000, 1'b1},  // C.EBREAK
        '{32'h0000_9282, 32'h0002_80E7, 1'b0},  // C.JALR x5
        '{32'h0000_852E, 32'h00B0_0533, 1'b0},  // C.MV x10, x11
        '{32'h0000_952E, 32'h00B5_0533, 1'b0},  // C.ADD x10, x11
        '{32'h0000_8002, 32'h0000_0000, 1'b1},  // C.JR with rs1 x0
        '{32'h0000_6141, 32'h0000_0000, 1'b1},  // C.ADDI16SP
        '{32'h0000_6301, 32'h0000_0000, 1'b1},  // C.LUI with zero immediate
        '{32'h0000_4082, 32'h0000_0000, 1'b1},  // C.LWSP
        '{32'h0000_2000, 32'h0000_0000, 1'b1},  // C.FLD
        '{32'h0000_0040, 32'h0000_0000, 1'b1},  // C.ADDI4SPN
        '{32'h0031_2023, 32'h0031_2023, 1'b0},  // sw x3, 0(x2) across two words
        '{32'h0000_0001, 32'h0000_0013, 1'b0}   // C.NOP fills the last word
    };

    rvc_pkg::fetch_word_t words[$];
    logic [15:0]          parcels[$];
    logic [31:0]          exp_pc        = rvc_pkg::RESET_PC;
    int                   errors        = 0;
    int                   rx_count      = 0;
    int                   word_idx      = 0;
    int                   credit_pulses = 0;
    int                   up_credits    = rvc_pkg::FETCH_CREDITS;
    int                   pending       = 0;  // Held by decode until its credit returns
    int                   delay         = 0;
    int unsigned          seed          = 32'h7778;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rvc_fetch_unit dut_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .fetch_credit (fetch_credit),
        .out_valid    (out_valid),
        .out_instr    (out_instr),
        .out_credit   (out_credit)
    );

    function automatic rvc_pkg::expanded_instr_t expected_for(input table_entry_t e,
                                                              input logic [31:0] pc);
        rvc_pkg::expanded_instr_t r;
        r.instr      = e.exp_instr;
        r.pc         = pc;
        r.compressed = e.code[1:0] != 2'b11;
        r.illegal    = e.exp_illegal;
        return r;
    endfunction

    task automatic check_instr(input int idx, input rvc_pkg::expanded_instr_t exp,
                               input rvc_pkg::expanded_instr_t act);
        if (act !== exp) begin
            errors++;
            $display(
                "Error out_instr[%0d] instr pc c ill: expected %h %h %h %h got %h %h %h %h",
                idx, exp.instr, exp.pc, exp.compressed, exp.illegal,
                act.instr, act.pc, act.compressed, act.illegal);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("Error %s count: expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h got %h", name, exp, act);
        end
    endtask

    task automatic report_and_finish(input logic timed_out);
        $display("Errors: %0d, instructions %0d of %0d, fetch credits %0d, timeout %0d",
                 errors, rx_count, NUM_ENTRIES, credit_pulses, timed_out);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    //////////////////////////////
    // Fetcher and decode models
    //////////////////////////////
    always @(negedge clk) begin
        if (rst) begin
            check_flag("out_valid in reset", 1'b0, out_valid);
            check_flag("fetch_credit in reset", 1'b0, fetch_credit);
        end else begin
            if (fetch_credit) begin
                up_credits++;
                credit_pulses++;
            end
            fetch_valid = 1'b0;
            if (up_credits > 0 && word_idx < words.size()) begin
                fetch_valid = 1'b1;  // Only while a credit is held
                fetch_data  = words[word_idx];
                word_idx++;
                up_credits--;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                if (rx_count < NUM_ENTRIES) begin
                    check_instr(rx_count, expected_for(tbl[rx_count], exp_pc), out_instr);
                    exp_pc = exp_pc + ((tbl[rx_count].code[1:0] == 2'b11) ? 4 : 2);
                end else begin
                    errors++;
                    $display("Error: an instruction arrived after the end of the program");
                end
                rx_count++;
                pending++;
                if (pending > rvc_pkg::OUT_CREDITS) begin
                    errors++;
                    $display("Error: %0d instructions outstanding, more than the decode slots",
                             pending);
                end
            end
            out_credit = 1'b0;
            if (pending > 0) begin
                if (delay == 0) begin
                    out_credit = 1'b1;
                    pending--;
                    delay = $urandom % 6;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        logic [15:0] lo;
        logic [15:0] hi;
        void'($urandom(seed));
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        out_credit  = 1'b0;
        foreach (tbl[i]) begin
            parcels.push_back(tbl[i].code[15:0]);
            if (tbl[i].code[1:0] == 2'b11) begin
                parcels.push_back(tbl[i].code[31:16]);
            end
        end
        while (parcels.size() >= 2) begin
            lo = parcels.pop_front();
            hi = parcels.pop_front();
            words.push_back(rvc_pkg::fetch_word_t'{hi_parcel: hi, lo_parcel: lo});
        end
        repeat (16) @(negedge clk);
        rst <= 1'b0;
        wait (rx_count >= NUM_ENTRIES && pending == 0);
        repeat (8) @(negedge clk);  // Let the last fetch credit come back
        check_count("instruction", NUM_ENTRIES, rx_count);
        check_count("word sent", words.size(), word_idx);
        check_count("fetch_credit pulse", words.size(), credit_pulses);
        report_and_finish(1'b0);
    end

    // Watchdog
    initial begin
        #(LIMIT);
        errors++;
        $display("Error: timeout, the program did not drain within %0d time units", LIMIT);
        report_and_finish(1'b1);
    end

endmodule

`default_nettype wire
